//--- ball_motion.sv
`timescale 1ns/10ps

module ball_motion #(
    parameter int H_VISIBLE       = pong_pkg::H_VISIBLE,
    parameter int V_VISIBLE       = pong_pkg::V_VISIBLE,
    parameter int BALL_SIZE       = pong_pkg::BALL_SIZE,
    parameter int BALL_SPEED      = pong_pkg::BALL_SPEED,
    parameter int PADDLE_WIDTH    = pong_pkg::PADDLE_WIDTH,
    parameter int PADDLE_HEIGHT   = pong_pkg::PADDLE_HEIGHT,
    parameter int OPP_PADDLE_X    = pong_pkg::OPP_PADDLE_X,
    parameter int PLAYER_PADDLE_X = pong_pkg::PLAYER_PADDLE_X
) (
    input  logic             clk_div,
    input  logic             rst_n,
    input  logic             game_tick,
    input  pong_pkg::coord_t paddle_y,
    input  pong_pkg::coord_t opp_paddle_y,
    output pong_pkg::coord_t ball_x,
    output pong_pkg::coord_t ball_y,
    output pong_pkg::score_t score
);

    localparam pong_pkg::coord_t SPEED    = pong_pkg::coord_t'(BALL_SPEED);
    localparam pong_pkg::coord_t SIZE     = pong_pkg::coord_t'(BALL_SIZE);
    localparam pong_pkg::coord_t PAD_H    = pong_pkg::coord_t'(PADDLE_HEIGHT);
    localparam pong_pkg::coord_t CENTER_X = pong_pkg::coord_t'(H_VISIBLE / 2);
    localparam pong_pkg::coord_t CENTER_Y = pong_pkg::coord_t'(V_VISIBLE / 2);
    localparam pong_pkg::coord_t OPP_FACE = pong_pkg::coord_t'(OPP_PADDLE_X + PADDLE_WIDTH);
    localparam pong_pkg::coord_t PLR_FACE = pong_pkg::coord_t'(PLAYER_PADDLE_X);
    localparam pong_pkg::coord_t Y_LIMIT  = pong_pkg::coord_t'(V_VISIBLE - BALL_SIZE - BALL_SPEED);
    localparam pong_pkg::coord_t X_LIMIT  = pong_pkg::coord_t'(H_VISIBLE - BALL_SIZE - BALL_SPEED);

    logic dir_x;      // 1 moves right
    logic dir_y;      // 1 moves down
    logic nxt_dir_x;
    logic nxt_dir_y;
    logic hit_opp;
    logic hit_player;
    logic miss_left;  // Player scores
    logic miss_right; // Opponent scores

    // Paddle faces only count when the ball travels toward them
    assign hit_opp    = !dir_x && (ball_x <= OPP_FACE)
                        && (ball_y >= opp_paddle_y) && (ball_y < opp_paddle_y + PAD_H);
    assign hit_player = dir_x && (ball_x + SIZE >= PLR_FACE)
                        && (ball_y >= paddle_y) && (ball_y < paddle_y + PAD_H);

    assign miss_left  = (ball_x <= SPEED);
    assign miss_right = (ball_x >= X_LIMIT);

    always_comb begin
        nxt_dir_x = dir_x;
        if (hit_opp)
            nxt_dir_x = 1'b1;
        else if (hit_player)
            nxt_dir_x = 1'b0;

        nxt_dir_y = dir_y;
        if (!dir_y && (ball_y <= SPEED))
            nxt_dir_y = 1'b1;  // Top wall
        else if (dir_y && (ball_y >= Y_LIMIT))
            nxt_dir_y = 1'b0;  // Bottom wall
    end

    always_ff @(posedge clk_div) begin
        if (!rst_n) begin
            ball_x <= CENTER_X;
            ball_y <= CENTER_Y;
            dir_x  <= 1'b1;
            dir_y  <= 1'b1;
            score  <= '0;
        end else if (game_tick) begin
            dir_x <= nxt_dir_x;  // Kept across a re-centre
            dir_y <= nxt_dir_y;
            if (miss_left || miss_right) begin
                ball_x <= CENTER_X;
                ball_y <= CENTER_Y;
            end else begin
                ball_x <= nxt_dir_x ? ball_x + SPEED : ball_x - SPEED;
                ball_y <= nxt_dir_y ? ball_y + SPEED : ball_y - SPEED;
            end
            // Each nibble stops at 9
            if (miss_left && (score.player < 4'd9))
                score.player <= score.player + 4'd1;
            if (miss_right && (score.opp < 4'd9))
                score.opp <= score.opp + 4'd1;
        end
    end

endmodule

//--- paddle_control.sv
`timescale 1ns/10ps

module paddle_control #(
    parameter int V_VISIBLE     = pong_pkg::V_VISIBLE,
    parameter int PADDLE_HEIGHT = pong_pkg::PADDLE_HEIGHT,
    parameter int PADDLE_SPEED  = pong_pkg::PADDLE_SPEED
) (
    input  logic               clk_div,
    input  logic               rst_n,
    input  logic               game_tick,
    input  pong_pkg::buttons_t buttons,
    input  pong_pkg::coord_t   ball_y,
    output pong_pkg::coord_t   paddle_y,
    output pong_pkg::coord_t   opp_paddle_y
);

    localparam pong_pkg::coord_t SPEED  = pong_pkg::coord_t'(PADDLE_SPEED);
    localparam pong_pkg::coord_t HALF_H = pong_pkg::coord_t'(PADDLE_HEIGHT / 2);
    localparam pong_pkg::coord_t BOTTOM = pong_pkg::coord_t'(V_VISIBLE - PADDLE_HEIGHT - PADDLE_SPEED);
    localparam pong_pkg::coord_t START  = pong_pkg::coord_t'((V_VISIBLE - PADDLE_HEIGHT) / 2);

    pong_pkg::coord_t opp_center;  // Middle row of the opponent paddle

    assign opp_center = opp_paddle_y + HALF_H;

    // Player paddle, up wins when both buttons are held
    always_ff @(posedge clk_div) begin
        if (!rst_n) begin
            paddle_y <= START;
        end else if (game_tick) begin
            if (buttons.up) begin
                if (paddle_y >= SPEED)
                    paddle_y <= paddle_y - SPEED;
            end else if (buttons.down && (paddle_y <= BOTTOM)) begin
                paddle_y <= paddle_y + SPEED;
            end
        end
    end

    // Opponent steers its centre toward the ball
    always_ff @(posedge clk_div) begin
        if (!rst_n) begin
            opp_paddle_y <= START;
        end else if (game_tick) begin
            if ((ball_y < opp_center) && (opp_paddle_y >= SPEED))
                opp_paddle_y <= opp_paddle_y - SPEED;
            else if ((ball_y > opp_center) && (opp_paddle_y <= BOTTOM))
                opp_paddle_y <= opp_paddle_y + SPEED;  // Holds when already centred
        end
    end

endmodule

//--- pixel_renderer.sv
`timescale 1ns/10ps

module pixel_renderer #(
    parameter int H_VISIBLE       = pong_pkg::H_VISIBLE,
    parameter int V_VISIBLE       = pong_pkg::V_VISIBLE,
    parameter int BALL_SIZE       = pong_pkg::BALL_SIZE,
    parameter int PADDLE_WIDTH    = pong_pkg::PADDLE_WIDTH,
    parameter int PADDLE_HEIGHT   = pong_pkg::PADDLE_HEIGHT,
    parameter int OPP_PADDLE_X    = pong_pkg::OPP_PADDLE_X,
    parameter int PLAYER_PADDLE_X = pong_pkg::PLAYER_PADDLE_X,
    parameter int MID_LINE_WIDTH  = pong_pkg::MID_LINE_WIDTH
) (
    input  logic                  clk_div,
    input  logic                  rst_n,
    input  pong_pkg::coord_t      h_count,
    input  pong_pkg::coord_t      v_count,
    input  logic                  h_blank_sync,
    input  logic                  v_blank_sync,
    input  pong_pkg::game_state_t state,
    output pong_pkg::vga_pixel_t  vga
);

    localparam pong_pkg::coord_t H_VIS   = pong_pkg::coord_t'(H_VISIBLE);
    localparam pong_pkg::coord_t V_VIS   = pong_pkg::coord_t'(V_VISIBLE);
    localparam pong_pkg::coord_t SIZE    = pong_pkg::coord_t'(BALL_SIZE);
    localparam pong_pkg::coord_t PAD_H   = pong_pkg::coord_t'(PADDLE_HEIGHT);
    localparam pong_pkg::coord_t OPP_L   = pong_pkg::coord_t'(OPP_PADDLE_X);
    localparam pong_pkg::coord_t OPP_R   = pong_pkg::coord_t'(OPP_PADDLE_X + PADDLE_WIDTH);
    localparam pong_pkg::coord_t PLR_L   = pong_pkg::coord_t'(PLAYER_PADDLE_X);
    localparam pong_pkg::coord_t PLR_R   = pong_pkg::coord_t'(PLAYER_PADDLE_X + PADDLE_WIDTH);
    localparam pong_pkg::coord_t MID_X   = pong_pkg::coord_t'(H_VISIBLE / 2);
    localparam pong_pkg::coord_t MID_HLF = pong_pkg::coord_t'(MID_LINE_WIDTH / 2);

    logic       visible;
    logic       in_opp;
    logic       in_player;
    logic       in_ball;
    logic       in_mid;
    logic [5:0] color;  // {red, green, blue}

    assign visible = (h_count < H_VIS) && (v_count < V_VIS);

    // Hit tests, all half-open ranges from the top-left corner
    assign in_opp    = (h_count >= OPP_L) && (h_count < OPP_R)
                       && (v_count >= state.opp_paddle_y)
                       && (v_count < state.opp_paddle_y + PAD_H);
    assign in_player = (h_count >= PLR_L) && (h_count < PLR_R)
                       && (v_count >= state.paddle_y)
                       && (v_count < state.paddle_y + PAD_H);
    assign in_ball   = (h_count >= state.ball_x) && (h_count < state.ball_x + SIZE)
                       && (v_count >= state.ball_y) && (v_count < state.ball_y + SIZE);
    assign in_mid    = (h_count + MID_HLF >= MID_X) && (h_count < MID_X + MID_HLF);

    always_comb begin
        if (!visible)
            color = 6'b0;  // Blanking stays black
        else if (in_opp || in_player)
            color = pong_pkg::COLOR_WHITE;
        else if (in_ball)
            color = pong_pkg::COLOR_WHITE;  // Paddles drawn over the ball
        else if (in_mid)
            color = pong_pkg::COLOR_PURPLE;
        else
            color = 6'b0;
    end

    // Syncs and colour leave on the same edge, one cycle behind the counters
    always_ff @(posedge clk_div) begin
        if (!rst_n) begin
            vga.vsync <= 1'b1;
            vga.hsync <= 1'b1;
            {vga.red, vga.green, vga.blue} <= 6'b0;
        end else begin
            vga.vsync <= v_blank_sync;
            vga.hsync <= h_blank_sync;
            {vga.red, vga.green, vga.blue} <= color;
        end
    end

endmodule

//--- pong_pkg.sv
package pong_pkg;

    typedef logic [9:0] coord_t;  // Screen coordinate, covers the full 800x525 raster

    typedef struct packed {
        logic up;
        logic down;
    } buttons_t;

    // Opponent in the upper nibble, player in the lower one
    typedef struct packed {
        logic [3:0] opp;
        logic [3:0] player;
    } score_t;

    typedef struct packed {
        coord_t ball_x;        // Top-left corner of the ball
        coord_t ball_y;
        coord_t paddle_y;      // Top edge of the player paddle
        coord_t opp_paddle_y;  // Top edge of the opponent paddle
        score_t score;
    } game_state_t;

    // Output byte as it leaves the pins, vsync on the MSB
    typedef struct packed {
        logic       vsync;
        logic       hsync;
        logic [1:0] red;
        logic [1:0] green;
        logic [1:0] blue;
    } vga_pixel_t;

    // 640x480 at 60 Hz, 800x525 total
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;

    // Game geometry and speed
    localparam int FRAME_DIV       = 2;    // Frames per game tick
    localparam int BALL_SIZE       = 10;
    localparam int BALL_SPEED      = 2;
    localparam int PADDLE_WIDTH    = 10;
    localparam int PADDLE_HEIGHT   = 60;
    localparam int PADDLE_SPEED    = 2;
    localparam int OPP_PADDLE_X    = 30;   // Left column of the opponent paddle
    localparam int PLAYER_PADDLE_X = 600;  // Left column of the player paddle
    localparam int MID_LINE_WIDTH  = 4;

    // RGB as {red, green, blue}, two bits each
    localparam logic [5:0] COLOR_WHITE  = 6'b11_11_11;
    localparam logic [5:0] COLOR_PURPLE = 6'b11_00_11;

endpackage

//--- pong_sva.sv
`timescale 1ns/10ps

module pong_sva #(
    parameter int V_VISIBLE     = pong_pkg::V_VISIBLE,
    parameter int PADDLE_HEIGHT = pong_pkg::PADDLE_HEIGHT
) (
    input logic                 clk_div,
    input logic                 rst_n,
    input pong_pkg::vga_pixel_t vga,
    input logic                 game_tick,
    input pong_pkg::score_t     score,
    input pong_pkg::coord_t     paddle_y,
    input pong_pkg::coord_t     opp_paddle_y
);

    localparam pong_pkg::coord_t PAD_MAX = pong_pkg::coord_t'(V_VISIBLE - PADDLE_HEIGHT);

    // Colour must be off while either sync is active
    blank_black: assert property (@(posedge clk_div) disable iff (!rst_n)
        (!vga.hsync || !vga.vsync) |-> ({vga.red, vga.green, vga.blue} == 6'b0))
        else $error("RGB not black during sync");

    single_tick: assert property (@(posedge clk_div) disable iff (!rst_n)
        game_tick |=> !game_tick)
        else $error("game_tick high on two cycles in a row");

    score_range: assert property (@(posedge clk_div) disable iff (!rst_n)
        (score.player <= 4'd9) && (score.opp <= 4'd9))
        else $error("Score nibble above 9");

    // Lower bound is 0, implied by unsigned coordinates
    paddle_range: assert property (@(posedge clk_div) disable iff (!rst_n)
        (paddle_y <= PAD_MAX) && (opp_paddle_y <= PAD_MAX))
        else $error("Paddle left the screen");

endmodule

bind pong_top pong_sva #(
    .V_VISIBLE(V_VISIBLE), .PADDLE_HEIGHT(PADDLE_HEIGHT)
) u_sva (
    .clk_div, .rst_n, .vga, .game_tick, .score, .paddle_y, .opp_paddle_y
);

//--- pong_top.sv
`timescale 1ns/10ps

module pong_top #(
    parameter int H_VISIBLE       = pong_pkg::H_VISIBLE,
    parameter int H_FRONT         = pong_pkg::H_FRONT,
    parameter int H_SYNC          = pong_pkg::H_SYNC,
    parameter int H_BACK          = pong_pkg::H_BACK,
    parameter int V_VISIBLE       = pong_pkg::V_VISIBLE,
    parameter int V_FRONT         = pong_pkg::V_FRONT,
    parameter int V_SYNC          = pong_pkg::V_SYNC,
    parameter int V_BACK          = pong_pkg::V_BACK,
    parameter int FRAME_DIV       = pong_pkg::FRAME_DIV,
    parameter int BALL_SIZE       = pong_pkg::BALL_SIZE,
    parameter int BALL_SPEED      = pong_pkg::BALL_SPEED,
    parameter int PADDLE_WIDTH    = pong_pkg::PADDLE_WIDTH,
    parameter int PADDLE_HEIGHT   = pong_pkg::PADDLE_HEIGHT,
    parameter int PADDLE_SPEED    = pong_pkg::PADDLE_SPEED,
    parameter int OPP_PADDLE_X    = pong_pkg::OPP_PADDLE_X,
    parameter int PLAYER_PADDLE_X = pong_pkg::PLAYER_PADDLE_X,
    parameter int MID_LINE_WIDTH  = pong_pkg::MID_LINE_WIDTH
) (
    input  logic                  clk_div,
    input  logic                  rst_n,
    input  pong_pkg::buttons_t    buttons,
    output pong_pkg::vga_pixel_t  vga,
    output pong_pkg::game_state_t state
);

    pong_pkg::coord_t h_count;
    pong_pkg::coord_t v_count;
    logic             h_blank_sync;
    logic             v_blank_sync;
    logic             game_tick;     // One pulse per FRAME_DIV frames
    pong_pkg::coord_t ball_x;
    pong_pkg::coord_t ball_y;
    pong_pkg::coord_t paddle_y;
    pong_pkg::coord_t opp_paddle_y;
    pong_pkg::score_t score;

    // Game state bundle, also read back by the renderer
    assign state = '{ball_x: ball_x, ball_y: ball_y, paddle_y: paddle_y,
                     opp_paddle_y: opp_paddle_y, score: score};

    vga_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .FRAME_DIV(FRAME_DIV)
    ) u_timing (
        .clk_div, .rst_n, .h_count, .v_count, .h_blank_sync, .v_blank_sync, .game_tick
    );

    ball_motion #(
        .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE),
        .BALL_SIZE(BALL_SIZE), .BALL_SPEED(BALL_SPEED),
        .PADDLE_WIDTH(PADDLE_WIDTH), .PADDLE_HEIGHT(PADDLE_HEIGHT),
        .OPP_PADDLE_X(OPP_PADDLE_X), .PLAYER_PADDLE_X(PLAYER_PADDLE_X)
    ) u_ball (
        .clk_div, .rst_n, .game_tick, .paddle_y, .opp_paddle_y, .ball_x, .ball_y, .score
    );

    paddle_control #(
        .V_VISIBLE(V_VISIBLE), .PADDLE_HEIGHT(PADDLE_HEIGHT), .PADDLE_SPEED(PADDLE_SPEED)
    ) u_paddles (
        .clk_div, .rst_n, .game_tick, .buttons, .ball_y, .paddle_y, .opp_paddle_y
    );

    pixel_renderer #(
        .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE), .BALL_SIZE(BALL_SIZE),
        .PADDLE_WIDTH(PADDLE_WIDTH), .PADDLE_HEIGHT(PADDLE_HEIGHT),
        .OPP_PADDLE_X(OPP_PADDLE_X), .PLAYER_PADDLE_X(PLAYER_PADDLE_X),
        .MID_LINE_WIDTH(MID_LINE_WIDTH)
    ) u_render (
        .clk_div, .rst_n, .h_count, .v_count, .h_blank_sync, .v_blank_sync, .state, .vga
    );

endmodule

//--- run.sh
#!/bin/bash
# Build the testbench with Verilator, then run it
# Exit status is nonzero when the simulation fails
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_pong -f tb.f -o tb_pong_sim \
    && ./obj_dir/tb_pong_sim \
    || { echo "Simulation did not pass"; exit 1; }

//--- tb.f
pong_pkg.sv
vga_timing.sv
ball_motion.sv
paddle_control.sv
pixel_renderer.sv
pong_top.sv
pong_sva.sv
tb_pong.sv

//--- tb_pong.sv
`timescale 1ns/10ps

module tb_pong;

    // Small screen, 80x55 total
    localparam int H_VISIBLE       = 64;
    localparam int H_FRONT         = 4;
    localparam int H_SYNC          = 8;
    localparam int H_BACK          = 4;
    localparam int V_VISIBLE       = 48;
    localparam int V_FRONT         = 2;
    localparam int V_SYNC          = 2;
    localparam int V_BACK          = 3;
    localparam int FRAME_DIV       = 2;
    localparam int BALL_SIZE       = 2;
    localparam int BALL_SPEED      = 1;
    localparam int PADDLE_WIDTH    = 2;
    localparam int PADDLE_HEIGHT   = 12;
    localparam int PADDLE_SPEED    = 1;
    localparam int OPP_PADDLE_X    = 4;
    localparam int PLAYER_PADDLE_X = 58;
    localparam int MID_LINE_WIDTH  = 2;
    localparam int H_TOTAL         = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL         = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int TICK_CYCLES     = FRAME_DIV * H_TOTAL * V_TOTAL;  // Cycles between ticks
    localparam int PAD_START       = (V_VISIBLE - PADDLE_HEIGHT) / 2;
    localparam int PAD_BOTTOM      = V_VISIBLE - PADDLE_HEIGHT;
    localparam int NUM_ROWS        = 11;

    logic                  clk_div = 1'b0;
    logic                  rst_n;
    pong_pkg::buttons_t    buttons;
    pong_pkg::vga_pixel_t  vga;
    pong_pkg::game_state_t state;

    // Buttons as {up, down}, ticks to hold them, player paddle row after the row
    pong_pkg::buttons_t stim_buttons [NUM_ROWS] = '{2'b00, 2'b10, 2'b01, 2'b11, 2'b10,
                                                    2'b01, 2'b11, 2'b00, 2'b01, 2'b10, 2'b00};
    // Long final idle row, ten misses on the right push the opponent nibble past 9
    int stim_ticks  [NUM_ROWS] = '{3, 4, 6, 3, 22, 40, 2, 3, 2, 3, 640};
    int stim_paddle [NUM_ROWS] = '{18, 14, 20, 17, 0, 36, 34, 34, 36, 33, 33};

    // Reference model state
    int   m_h, m_v, m_frame;
    int   m_bx, m_by, m_dx, m_dy;
    int   m_pad, m_opp;
    int   m_score_p, m_score_o;
    logic [7:0] exp_vga;
    bit   checking    = 1'b0;  // Set once the first reset edge is seen
    int   ticks_done  = 0;
    int   error_count = 0;
    int   cycle_count = 0;
    int   cycle_limit;
    int   target;

    always #10 clk_div = ~clk_div;  // 20 ns period

    pong_top #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .FRAME_DIV(FRAME_DIV), .BALL_SIZE(BALL_SIZE), .BALL_SPEED(BALL_SPEED),
        .PADDLE_WIDTH(PADDLE_WIDTH), .PADDLE_HEIGHT(PADDLE_HEIGHT),
        .PADDLE_SPEED(PADDLE_SPEED), .OPP_PADDLE_X(OPP_PADDLE_X),
        .PLAYER_PADDLE_X(PLAYER_PADDLE_X), .MID_LINE_WIDTH(MID_LINE_WIDTH)
    ) uut (
        .clk_div, .rst_n, .buttons, .vga, .state
    );

    task automatic abort_run();
        error_count++;
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Active low inside [start, start+width)
    function automatic logic sync_level(input int count, input int start, input int width);
        return !((count >= start) && (count < start + width));
    endfunction

    // Colour priority: blanking, paddles, ball, centre line, background
    function automatic logic [5:0] pixel_color(input int h, input int v, input int bx,
                                               input int by, input int pad, input int opp);
        if (h >= H_VISIBLE || v >= V_VISIBLE)
            return 6'b0;
        if (h >= OPP_PADDLE_X && h < OPP_PADDLE_X + PADDLE_WIDTH
            && v >= opp && v < opp + PADDLE_HEIGHT)
            return pong_pkg::COLOR_WHITE;
        if (h >= PLAYER_PADDLE_X && h < PLAYER_PADDLE_X + PADDLE_WIDTH
            && v >= pad && v < pad + PADDLE_HEIGHT)
            return pong_pkg::COLOR_WHITE;
        if (h >= bx && h < bx + BALL_SIZE && v >= by && v < by + BALL_SIZE)
            return pong_pkg::COLOR_WHITE;
        if (h >= H_VISIBLE / 2 - MID_LINE_WIDTH / 2 && h < H_VISIBLE / 2 + MID_LINE_WIDTH / 2)
            return pong_pkg::COLOR_PURPLE;
        return 6'b0;
    endfunction

    // Reference model, one step per rising edge
    always @(posedge clk_div) begin : ref_model
        int  nbx, nby, ndx, ndy, npad, nopp, centre;
        bit  tick;
        if (!rst_n) begin
            m_h = 0;
            m_v = 0;
            m_frame = 0;
            m_bx = H_VISIBLE / 2;
            m_by = V_VISIBLE / 2;
            m_dx = 1;  // Right and down
            m_dy = 1;
            m_pad = PAD_START;
            m_opp = PAD_START;
            m_score_p = 0;
            m_score_o = 0;
            exp_vga = 8'hc0;  // Syncs high, black
            checking = 1'b1;
        end else begin
            exp_vga = {sync_level(m_v, V_VISIBLE + V_FRONT, V_SYNC),
                       sync_level(m_h, H_VISIBLE + H_FRONT, H_SYNC),
                       pixel_color(m_h, m_v, m_bx, m_by, m_pad, m_opp)};
            tick = (m_h == H_TOTAL - 1) && (m_v == V_TOTAL - 1) && (m_frame == FRAME_DIV - 1);
            if (tick) begin
                ndx = m_dx;
                if (m_dx == 0 && m_bx <= OPP_PADDLE_X + PADDLE_WIDTH
                    && m_by >= m_opp && m_by < m_opp + PADDLE_HEIGHT)
                    ndx = 1;
                else if (m_dx == 1 && m_bx + BALL_SIZE >= PLAYER_PADDLE_X
                         && m_by >= m_pad && m_by < m_pad + PADDLE_HEIGHT)
                    ndx = 0;
                ndy = m_dy;
                if (m_dy == 0 && m_by <= BALL_SPEED)
                    ndy = 1;
                else if (m_dy == 1 && m_by >= V_VISIBLE - BALL_SIZE - BALL_SPEED)
                    ndy = 0;
                nbx = (ndx == 1) ? m_bx + BALL_SPEED : m_bx - BALL_SPEED;
                nby = (ndy == 1) ? m_by + BALL_SPEED : m_by - BALL_SPEED;
                if (m_bx <= BALL_SPEED || m_bx >= H_VISIBLE - BALL_SIZE - BALL_SPEED) begin
                    nbx = H_VISIBLE / 2;  // Missed, back to the centre
                    nby = V_VISIBLE / 2;
                end
                if (m_bx <= BALL_SPEED && m_score_p < 9)
                    m_score_p++;
                if (m_bx >= H_VISIBLE - BALL_SIZE - BALL_SPEED && m_score_o < 9)
                    m_score_o++;
                npad = m_pad;
                if (buttons.up) begin
                    if (m_pad >= PADDLE_SPEED)
                        npad = m_pad - PADDLE_SPEED;
                end else if (buttons.down && m_pad <= PAD_BOTTOM - PADDLE_SPEED) begin
                    npad = m_pad + PADDLE_SPEED;
                end
                centre = m_opp + PADDLE_HEIGHT / 2;
                nopp = m_opp;
                if (m_by < centre && m_opp >= PADDLE_SPEED)
                    nopp = m_opp - PADDLE_SPEED;
                else if (m_by > centre && m_opp <= PAD_BOTTOM - PADDLE_SPEED)
                    nopp = m_opp + PADDLE_SPEED;
                m_bx = nbx;
                m_by = nby;
                m_dx = ndx;
                m_dy = ndy;
                m_pad = npad;
                m_opp = nopp;
                ticks_done++;
            end
            if (m_h == H_TOTAL - 1) begin
                m_h = 0;
                if (m_v == V_TOTAL - 1) begin
                    m_v = 0;
                    m_frame = (m_frame == FRAME_DIV - 1) ? 0 : m_frame + 1;
                end else begin
                    m_v = m_v + 1;
                end
            end else begin
                m_h = m_h + 1;
            end
        end
    end

    // Compare on the falling edge, away from the DUT's updates
    always @(negedge clk_div) begin
        if (checking) begin
            check_value("vga", 48'(vga), 48'(exp_vga));
            check_value("ball_x", 48'(state.ball_x), 48'(m_bx));
            check_value("ball_y", 48'(state.ball_y), 48'(m_by));
            check_value("paddle_y", 48'(state.paddle_y), 48'(m_pad));
            check_value("opp_paddle_y", 48'(state.opp_paddle_y), 48'(m_opp));
            check_value("score", 48'(state.score), 48'(m_score_o * 16 + m_score_p));
        end
    end

    always @(posedge clk_div) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus table did not complete",
                     cycle_count);
            abort_run();
        end
    end

    initial begin
        rst_n   = 1'b0;
        buttons = '0;
        cycle_limit = 2;
        foreach (stim_ticks[i])
            cycle_limit += stim_ticks[i];
        cycle_limit = cycle_limit * TICK_CYCLES;
        repeat (2) @(posedge clk_div);
        rst_n <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            target = ticks_done + stim_ticks[r];
            @(posedge clk_div);
            buttons <= stim_buttons[r];
            while (ticks_done < target)
                @(negedge clk_div);
            check_value("paddle_y after row", 48'(state.paddle_y), 48'(stim_paddle[r]));
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "Errors were found");
        end
    end

endmodule

//--- vga_timing.sv
`timescale 1ns/10ps

module vga_timing #(
    parameter int H_VISIBLE = pong_pkg::H_VISIBLE,
    parameter int H_FRONT   = pong_pkg::H_FRONT,
    parameter int H_SYNC    = pong_pkg::H_SYNC,
    parameter int H_BACK    = pong_pkg::H_BACK,
    parameter int V_VISIBLE = pong_pkg::V_VISIBLE,
    parameter int V_FRONT   = pong_pkg::V_FRONT,
    parameter int V_SYNC    = pong_pkg::V_SYNC,
    parameter int V_BACK    = pong_pkg::V_BACK,
    parameter int FRAME_DIV = pong_pkg::FRAME_DIV
) (
    input  logic             clk_div,
    input  logic             rst_n,
    output pong_pkg::coord_t h_count,
    output pong_pkg::coord_t v_count,
    output logic             h_blank_sync,  // Active low
    output logic             v_blank_sync,  // Active low
    output logic             game_tick
);

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int FW      = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

    // Sync windows and wrap points as screen coordinates
    localparam pong_pkg::coord_t H_LAST   = pong_pkg::coord_t'(H_TOTAL - 1);
    localparam pong_pkg::coord_t V_LAST   = pong_pkg::coord_t'(V_TOTAL - 1);
    localparam pong_pkg::coord_t HS_START = pong_pkg::coord_t'(H_VISIBLE + H_FRONT);
    localparam pong_pkg::coord_t HS_END   = pong_pkg::coord_t'(H_VISIBLE + H_FRONT + H_SYNC);
    localparam pong_pkg::coord_t VS_START = pong_pkg::coord_t'(V_VISIBLE + V_FRONT);
    localparam pong_pkg::coord_t VS_END   = pong_pkg::coord_t'(V_VISIBLE + V_FRONT + V_SYNC);

    logic [FW-1:0] frame_cnt;  // Frames since the last tick
    logic          line_end;
    logic          frame_end;

    assign line_end  = (h_count == H_LAST);
    assign frame_end = line_end && (v_count == V_LAST);  // Last pixel of the frame

    always_ff @(posedge clk_div) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= frame_end ? '0 : v_count + 10'd1;
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    // Slows the game to a playable rate
    always_ff @(posedge clk_div) begin
        if (!rst_n)
            frame_cnt <= '0;
        else if (frame_end)
            frame_cnt <= (frame_cnt == FW'(FRAME_DIV - 1)) ? '0 : frame_cnt + FW'(1);
    end

    assign game_tick = frame_end && (frame_cnt == FW'(FRAME_DIV - 1));  // One cycle wide

    // Raw sync levels, low inside the sync window
    assign h_blank_sync = !((h_count >= HS_START) && (h_count < HS_END));
    assign v_blank_sync = !((v_count >= VS_START) && (v_count < VS_END));

endmodule
